// ==== logic/arena_pkg.sv ====
package arena_pkg;

	typedef logic signed [10:0] coord_t;
	typedef logic [9:0] rail_t;
	typedef logic [6:0] score_t;
	typedef logic [3:0] digit_t;
	typedef logic [7:0] channel_t;

	// 640x480 raster, counted from the start of sync
	localparam int H_TOTAL = 800;
	localparam int V_TOTAL = 525;
	localparam int H_SYNC_END = 95;
	localparam int V_SYNC_END = 1;

	localparam coord_t ACTIVE_X_MIN = 143; // exclusive bounds
	localparam coord_t ACTIVE_X_MAX = 784;
	localparam coord_t ACTIVE_Y_MIN = 34;
	localparam coord_t ACTIVE_Y_MAX = 515;
	localparam coord_t FIELD_X_END = 660; // separator column

	localparam coord_t BORDER_LEFT = 144;
	localparam coord_t BORDER_RIGHT = 659;
	localparam coord_t BORDER_TOP = 35;
	localparam coord_t BORDER_BOTTOM = 513;
	localparam coord_t HALF_LINE_Y = 275;

	localparam coord_t BLUE_GOAL1_X = 300;
	localparam coord_t BLUE_GOAL1_Y = 470;
	localparam coord_t BLUE_GOAL2_X = 400;
	localparam coord_t BLUE_GOAL2_Y = 430;
	localparam coord_t BLUE_GOAL3_X = 500;
	localparam coord_t BLUE_GOAL3_Y = 470;
	localparam coord_t RED_GOAL1_X = 300;
	localparam coord_t RED_GOAL1_Y = 80;
	localparam coord_t RED_GOAL2_X = 400;
	localparam coord_t RED_GOAL2_Y = 120;
	localparam coord_t RED_GOAL3_X = 500;
	localparam coord_t RED_GOAL3_Y = 80;
	localparam int GOAL_RING = 2; // ring and post half-width

	localparam coord_t BLUE_VER_X = 240;
	localparam coord_t BLUE_HOR_Y = 370;
	localparam coord_t RED_VER_X = 560;
	localparam coord_t RED_HOR_Y = 180;

	localparam int BLUE_TENS_X = 676;
	localparam int BLUE_ONES_X = 698;
	localparam int RED_TENS_X = 738;
	localparam int RED_ONES_X = 762;
	localparam int SCORE_Y = 100;

	localparam channel_t BOARD_R = 200; // light grey-green
	localparam channel_t BOARD_G = 210;
	localparam channel_t BOARD_B = 200;

endpackage

// ==== logic/raster_timing.sv ====
module raster_timing (
	input  logic clk,
	input  logic rst_n,
	input  logic pix_en,
	output arena_pkg::coord_t x,
	output arena_pkg::coord_t y,
	output logic hor_sync,
	output logic ver_sync,
	output logic in_active,
	output logic in_field
);
	import arena_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x <= '0;
			y <= '0;
		end else if (pix_en) begin
			if (x == H_TOTAL - 1) begin
				x <= '0;
				if (y == V_TOTAL - 1) begin // end of frame
					y <= '0;
				end else begin
					y <= y + 1'b1;
				end
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	assign hor_sync = x > H_SYNC_END; // low during the sync pulse
	assign ver_sync = y > V_SYNC_END;

	assign in_active = (x > ACTIVE_X_MIN) && (x < ACTIVE_X_MAX) &&
		(y > ACTIVE_Y_MIN) && (y < ACTIVE_Y_MAX);
	assign in_field = x < FIELD_X_END;

endmodule

// ==== logic/pitch_painter.sv ====
module pitch_painter #(
	parameter int player_radius = 25,
	parameter int goal_radius = 40,
	parameter int ball_radius = 5,
	parameter int bludger_radius = 5
) (
	input  arena_pkg::coord_t x,
	input  arena_pkg::coord_t y,
	input  arena_pkg::rail_t team1_ver_pos,
	input  arena_pkg::rail_t team1_hor_pos,
	input  arena_pkg::rail_t team2_ver_pos,
	input  arena_pkg::rail_t team2_hor_pos,
	input  arena_pkg::coord_t ball_x,
	input  arena_pkg::coord_t ball_y,
	input  arena_pkg::coord_t bludger_x,
	input  arena_pkg::coord_t bludger_y,
	output logic red_shape,
	output logic blue_shape,
	output logic line_hit,
	output logic ball_hit,
	output logic bludger_hit
);
	import arena_pkg::*;

	localparam int RING_IN_SQ = (goal_radius - GOAL_RING) ** 2;
	localparam int RING_OUT_SQ = (goal_radius + GOAL_RING) ** 2;

	coord_t t1_ver;
	coord_t t1_hor;
	coord_t t2_ver;
	coord_t t2_hor;
	logic blue_goals;
	logic red_goals;
	logic blue_players;
	logic red_players;

	function automatic logic [23:0] dist_sq(input coord_t ax, input coord_t ay,
			input coord_t bx, input coord_t by);
		logic signed [11:0] dx;
		logic signed [11:0] dy;
		logic signed [23:0] sq_x;
		logic signed [23:0] sq_y;
		dx = ax - bx;
		dy = ay - by;
		sq_x = dx * dx;
		sq_y = dy * dy;
		return sq_x + sq_y;
	endfunction

	// ring, plus a post running away from the field
	function automatic logic goal_hit(input coord_t px, input coord_t py, input coord_t cx,
			input coord_t cy, input logic post_below);
		logic [23:0] d;
		logic ring;
		logic post_col;
		logic post_row;
		d = dist_sq(px, py, cx, cy);
		ring = (d > RING_IN_SQ) && (d < RING_OUT_SQ);
		post_col = (px >= cx - GOAL_RING) && (px <= cx + GOAL_RING);
		if (post_below) begin
			post_row = py >= cy + goal_radius;
		end else begin
			post_row = py <= cy - goal_radius;
		end
		return ring || (post_col && post_row);
	endfunction

	assign t1_ver = coord_t'({1'b0, team1_ver_pos});
	assign t1_hor = coord_t'({1'b0, team1_hor_pos});
	assign t2_ver = coord_t'({1'b0, team2_ver_pos});
	assign t2_hor = coord_t'({1'b0, team2_hor_pos});

	assign blue_goals = goal_hit(x, y, BLUE_GOAL1_X, BLUE_GOAL1_Y, 1'b1) ||
		goal_hit(x, y, BLUE_GOAL2_X, BLUE_GOAL2_Y, 1'b1) ||
		goal_hit(x, y, BLUE_GOAL3_X, BLUE_GOAL3_Y, 1'b1);
	assign red_goals = goal_hit(x, y, RED_GOAL1_X, RED_GOAL1_Y, 1'b0) ||
		goal_hit(x, y, RED_GOAL2_X, RED_GOAL2_Y, 1'b0) ||
		goal_hit(x, y, RED_GOAL3_X, RED_GOAL3_Y, 1'b0);

	assign blue_players = (dist_sq(x, y, BLUE_VER_X, t1_ver) < player_radius ** 2) ||
		(dist_sq(x, y, t1_hor, BLUE_HOR_Y) < player_radius ** 2);
	assign red_players = (dist_sq(x, y, RED_VER_X, t2_ver) < player_radius ** 2) ||
		(dist_sq(x, y, t2_hor, RED_HOR_Y) < player_radius ** 2);

	assign red_shape = red_goals || red_players;
	assign blue_shape = blue_goals || blue_players;
	assign ball_hit = dist_sq(x, y, ball_x, ball_y) < ball_radius ** 2;
	assign bludger_hit = dist_sq(x, y, bludger_x, bludger_y) < bludger_radius ** 2;

	assign line_hit = (x == BORDER_LEFT) || (x == BORDER_RIGHT) ||
		(y == BORDER_TOP) || (y == BORDER_BOTTOM) || (y == HALF_LINE_Y);

endmodule

// ==== logic/segment_digit.sv ====
module segment_digit #(
	parameter int center_x = 0,
	parameter int center_y = 0
) (
	input  arena_pkg::coord_t x,
	input  arena_pkg::coord_t y,
	input  arena_pkg::digit_t value,
	output logic hit
);
	int dx;
	int dy;
	logic [6:0] lit; // top, ur, lr, bottom, ll, ul, middle
	logic [6:0] box;

	function automatic logic in_box(input int px, input int py, input int x_lo,
			input int x_hi, input int y_lo, input int y_hi);
		return (px >= x_lo) && (px <= x_hi) && (py >= y_lo) && (py <= y_hi);
	endfunction

	assign dx = int'(x) - center_x;
	assign dy = int'(y) - center_y;

	assign lit[6] = !(value == 4'd1 || value == 4'd4);
	assign lit[5] = !(value == 4'd5 || value == 4'd6);
	assign lit[4] = value != 4'd2;
	assign lit[3] = !(value == 4'd1 || value == 4'd4 || value == 4'd7);
	assign lit[2] = value == 4'd0 || value == 4'd2 || value == 4'd6 || value == 4'd8;
	assign lit[1] = !(value == 4'd1 || value == 4'd2 || value == 4'd3 || value == 4'd7);
	assign lit[0] = !(value == 4'd0 || value == 4'd1 || value == 4'd7);

	assign box[6] = in_box(dx, dy, -7, 7, -19, -17);
	assign box[5] = in_box(dx, dy, 8, 10, -16, -2);
	assign box[4] = in_box(dx, dy, 8, 10, 2, 16);
	assign box[3] = in_box(dx, dy, -7, 7, 17, 19);
	assign box[2] = in_box(dx, dy, -10, -8, 2, 16);
	assign box[1] = in_box(dx, dy, -10, -8, -16, -2);
	assign box[0] = in_box(dx, dy, -7, 7, -1, 1);

	assign hit = |(lit & box);

endmodule

// ==== logic/score_board.sv ====
module score_board (
	input  arena_pkg::coord_t x,
	input  arena_pkg::coord_t y,
	input  arena_pkg::score_t team1_score,
	input  arena_pkg::score_t team2_score,
	output logic blue_digit_hit,
	output logic red_digit_hit
);
	import arena_pkg::*;

	score_t blue_half;
	score_t red_half;
	digit_t blue_tens;
	digit_t blue_ones;
	digit_t red_tens;
	digit_t red_ones;
	logic [1:0] blue_hits;
	logic [1:0] red_hits;

	assign blue_half = team1_score >> 1; // two points per goal
	assign red_half = team2_score >> 1;
	assign blue_tens = digit_t'(blue_half / 7'd10);
	assign blue_ones = digit_t'(blue_half % 7'd10);
	assign red_tens = digit_t'(red_half / 7'd10);
	assign red_ones = digit_t'(red_half % 7'd10);

	segment_digit #(.center_x(BLUE_TENS_X), .center_y(SCORE_Y)) u_blue_tens (
		.x(x), .y(y), .value(blue_tens), .hit(blue_hits[1])
	);
	segment_digit #(.center_x(BLUE_ONES_X), .center_y(SCORE_Y)) u_blue_ones (
		.x(x), .y(y), .value(blue_ones), .hit(blue_hits[0])
	);
	segment_digit #(.center_x(RED_TENS_X), .center_y(SCORE_Y)) u_red_tens (
		.x(x), .y(y), .value(red_tens), .hit(red_hits[1])
	);
	segment_digit #(.center_x(RED_ONES_X), .center_y(SCORE_Y)) u_red_ones (
		.x(x), .y(y), .value(red_ones), .hit(red_hits[0])
	);

	assign blue_digit_hit = |blue_hits;
	assign red_digit_hit = |red_hits;

endmodule

// ==== logic/pixel_composer.sv ====
module pixel_composer (
	input  logic clk,
	input  logic rst_n,
	input  logic pix_en,
	input  arena_pkg::coord_t x,
	input  logic in_active,
	input  logic in_field,
	input  logic red_shape,
	input  logic blue_shape,
	input  logic line_hit,
	input  logic ball_hit,
	input  logic bludger_hit,
	input  logic blue_digit_hit,
	input  logic red_digit_hit,
	output arena_pkg::channel_t red,
	output arena_pkg::channel_t green,
	output arena_pkg::channel_t blue
);
	import arena_pkg::*;

	channel_t red_d;
	channel_t green_d;
	channel_t blue_d;

	always_comb begin
		red_d = '0;
		green_d = '0;
		blue_d = '0;
		if (in_active && in_field) begin
			if (red_shape || line_hit || ball_hit || bludger_hit)
				red_d = 8'hff;
			if ((blue_shape || line_hit || ball_hit) && !bludger_hit)
				blue_d = 8'hff; // bludger knocks out blue
			if ((line_hit || bludger_hit) && !ball_hit)
				green_d = 8'hff;
		end else if (in_active && x != FIELD_X_END) begin
			red_d = BOARD_R;
			green_d = BOARD_G;
			blue_d = BOARD_B;
			if (blue_digit_hit) begin
				red_d = 8'h00;
				green_d = 8'h00;
				blue_d = 8'hff;
			end
			if (red_digit_hit) begin // red drawn last, wins overlap
				red_d = 8'hff;
				green_d = 8'h00;
				blue_d = 8'h00;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else if (pix_en) begin
			red <= red_d;
			green <= green_d;
			blue <= blue_d;
		end
	end

endmodule

// ==== logic/arena_display.sv ====
module arena_display #(
	parameter int player_radius = 25,
	parameter int goal_radius = 40,
	parameter int ball_radius = 5,
	parameter int bludger_radius = 5
) (
	input  logic clk,
	input  logic rst_n,
	input  logic pix_en,
	input  arena_pkg::rail_t team1_ver_pos,
	input  arena_pkg::rail_t team1_hor_pos,
	input  arena_pkg::rail_t team2_ver_pos,
	input  arena_pkg::rail_t team2_hor_pos,
	input  arena_pkg::coord_t ball_x,
	input  arena_pkg::coord_t ball_y,
	input  arena_pkg::coord_t bludger_x,
	input  arena_pkg::coord_t bludger_y,
	input  arena_pkg::score_t team1_score,
	input  arena_pkg::score_t team2_score,
	output logic hor_sync,
	output logic ver_sync,
	output arena_pkg::channel_t red,
	output arena_pkg::channel_t green,
	output arena_pkg::channel_t blue
);
	import arena_pkg::*;

	coord_t x;
	coord_t y;
	logic in_active;
	logic in_field;
	logic red_shape;
	logic blue_shape;
	logic line_hit;
	logic ball_hit;
	logic bludger_hit;
	logic blue_digit_hit;
	logic red_digit_hit;

	raster_timing u_timing (
		.clk(clk), .rst_n(rst_n), .pix_en(pix_en), .x(x), .y(y),
		.hor_sync(hor_sync), .ver_sync(ver_sync),
		.in_active(in_active), .in_field(in_field)
	);

	pitch_painter #(
		.player_radius(player_radius), .goal_radius(goal_radius),
		.ball_radius(ball_radius), .bludger_radius(bludger_radius)
	) u_painter (
		.x(x), .y(y),
		.team1_ver_pos(team1_ver_pos), .team1_hor_pos(team1_hor_pos),
		.team2_ver_pos(team2_ver_pos), .team2_hor_pos(team2_hor_pos),
		.ball_x(ball_x), .ball_y(ball_y), .bludger_x(bludger_x), .bludger_y(bludger_y),
		.red_shape(red_shape), .blue_shape(blue_shape), .line_hit(line_hit),
		.ball_hit(ball_hit), .bludger_hit(bludger_hit)
	);

	score_board u_board (
		.x(x), .y(y), .team1_score(team1_score), .team2_score(team2_score),
		.blue_digit_hit(blue_digit_hit), .red_digit_hit(red_digit_hit)
	);

	pixel_composer u_composer (
		.clk(clk), .rst_n(rst_n), .pix_en(pix_en), .x(x),
		.in_active(in_active), .in_field(in_field),
		.red_shape(red_shape), .blue_shape(blue_shape), .line_hit(line_hit),
		.ball_hit(ball_hit), .bludger_hit(bludger_hit),
		.blue_digit_hit(blue_digit_hit), .red_digit_hit(red_digit_hit),
		.red(red), .green(green), .blue(blue)
	);

endmodule

// ==== tests/arena_display_assertions.sv ====
module arena_display_assertions (
	input logic clk,
	input logic rst_n,
	input logic pix_en,
	input arena_pkg::coord_t x,
	input arena_pkg::coord_t y,
	input logic hor_sync,
	input logic in_active,
	input arena_pkg::channel_t red,
	input arena_pkg::channel_t green,
	input arena_pkg::channel_t blue
);
	timeunit 1ns;
	timeprecision 100ps;
	import arena_pkg::*;

	property counters_in_range;
		@(posedge clk) disable iff (!rst_n)
			(x >= 0) && (x < H_TOTAL) && (y >= 0) && (y < V_TOTAL);
	endproperty

	// colour register picks up black for blanked pixels
	property blank_outside_active;
		@(posedge clk) disable iff (!rst_n)
			(pix_en && !in_active) |=> (red == '0) && (green == '0) && (blue == '0);
	endproperty

	// sync edges only where the counter crosses the pulse bounds
	property sync_follows_x;
		@(posedge clk) disable iff (!rst_n)
			pix_en |=> (hor_sync != $past(hor_sync)) ==
				(($past(x) == H_SYNC_END) || ($past(x) == H_TOTAL - 1));
	endproperty

	counter_range_check: assert property (counters_in_range)
		else $error("pixel or line counter out of range");
	blanking_check: assert property (blank_outside_active)
		else $error("colour not black after a blanked pixel");
	hor_sync_check: assert property (sync_follows_x)
		else $error("hor_sync does not match the pixel counter");

endmodule

bind arena_display arena_display_assertions u_checks (
	.clk(clk),
	.rst_n(rst_n),
	.pix_en(pix_en),
	.x(x),
	.y(y),
	.hor_sync(hor_sync),
	.in_active(in_active),
	.red(red),
	.green(green),
	.blue(blue)
);

// ==== tests/arena_display_tb.sv ====
module arena_display_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import arena_pkg::*;

	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

	logic clk;
	logic rst_n;
	logic pix_en;
	rail_t team1_ver_pos;
	rail_t team1_hor_pos;
	rail_t team2_ver_pos;
	rail_t team2_hor_pos;
	coord_t ball_x;
	coord_t ball_y;
	coord_t bludger_x;
	coord_t bludger_y;
	score_t team1_score;
	score_t team2_score;
	logic hor_sync;
	logic ver_sync;
	channel_t red;
	channel_t green;
	channel_t blue;

	int cur_x; // pixel the DUT is on now
	int cur_y;
	int errors;
	int checks;
	int fd;
	int code;
	int fields;
	int line_no;
	string line;
	int tx, ty;
	int t1v, t1h, t2v, t2h;
	int bx, by, gx, gy;
	int s1, s2;
	int er, eg, eb, ehs, evs;

	arena_display u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.team1_ver_pos(team1_ver_pos),
		.team1_hor_pos(team1_hor_pos),
		.team2_ver_pos(team2_ver_pos),
		.team2_hor_pos(team2_hor_pos),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.bludger_x(bludger_x),
		.bludger_y(bludger_y),
		.team1_score(team1_score),
		.team2_score(team2_score),
		.hor_sync(hor_sync),
		.ver_sync(ver_sync),
		.red(red),
		.green(green),
		.blue(blue)
	);

	always #50 clk = ~clk;

	// one pixel step, x first, then y
	task automatic next_cycle();
		@(posedge clk);
		#5;
		if (cur_x == H_TOTAL - 1) begin
			cur_x = 0;
			cur_y = (cur_y == V_TOTAL - 1) ? 0 : cur_y + 1;
		end else begin
			cur_x = cur_x + 1;
		end
	endtask

	task automatic wait_for_pixel(input int px, input int py, output bit found);
		int waited;
		waited = 0;
		while (!(cur_x == px && cur_y == py) && waited < FRAME_CYCLES) begin
			next_cycle();
			waited++;
		end
		found = (cur_x == px) && (cur_y == py);
		if (!found) begin
			errors++;
			$display("timed out waiting for pixel (%0d,%0d)", px, py);
		end
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		checks++;
		if (got != expected) begin
			errors++;
			$display("mismatch at pixel (%0d,%0d): %s = %h, expected %h",
				tx, ty, name, got, expected);
		end
	endtask

	task automatic apply_inputs();
		team1_ver_pos = rail_t'(t1v);
		team1_hor_pos = rail_t'(t1h);
		team2_ver_pos = rail_t'(t2v);
		team2_hor_pos = rail_t'(t2h);
		ball_x = coord_t'(bx);
		ball_y = coord_t'(by);
		bludger_x = coord_t'(gx);
		bludger_y = coord_t'(gy);
		team1_score = score_t'(s1);
		team2_score = score_t'(s2);
	endtask

	// sync in the pixel's own cycle, colour after the next edge
	task automatic probe_pixel();
		bit found;
		apply_inputs();
		wait_for_pixel(tx, ty, found);
		if (found) begin
			check_value("hor_sync", int'(hor_sync), ehs);
			check_value("ver_sync", int'(ver_sync), evs);
			next_cycle();
			check_value("red", int'(red), er);
			check_value("green", int'(green), eg);
			check_value("blue", int'(blue), eb);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		pix_en = 1'b1;
		team1_ver_pos = '0;
		team1_hor_pos = '0;
		team2_ver_pos = '0;
		team2_hor_pos = '0;
		ball_x = '0;
		ball_y = '0;
		bludger_x = '0;
		bludger_y = '0;
		team1_score = '0;
		team2_score = '0;
		errors = 0;
		checks = 0;
		cur_x = 0;
		cur_y = 0;
		line_no = 0;

		repeat (10) @(posedge clk);
		#5;
		rst_n = 1'b1;

		tx = 0; // counters rest at (0,0) here
		ty = 0;
		check_value("red", int'(red), 0);
		check_value("green", int'(green), 0);
		check_value("blue", int'(blue), 0);

		fd = $fopen("tests/arena_trace.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open tests/arena_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				line_no++;
				if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin // skip # lines
					fields = $sscanf(line,
						"%d %d %d %d %d %d %d %d %d %d %d %d %h %h %h %d %d",
						tx, ty, t1v, t1h, t2v, t2h, bx, by, gx, gy, s1, s2,
						er, eg, eb, ehs, evs);
					if (fields != 17) begin
						errors++;
						$display("trace line %0d could not be read", line_no);
					end else begin
						probe_pixel();
					end
				end
			end
			$fclose(fd);
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tests/arena_trace.txt ====
# x y team1_ver team1_hor team2_ver team2_hor ball_x ball_y bludger_x bludger_y score1 score2
# then expected red green blue (hex), hor_sync, ver_sync; probes in raster order
0 0 450 600 100 200 1000 1000 1000 1000 0 0 00 00 00 0 0
96 2 450 600 100 200 1000 1000 1000 1000 0 0 00 00 00 1 1
200 35 450 600 100 200 1000 1000 1000 1000 0 0 ff ff ff 1 1
300 38 450 600 100 200 1000 1000 1000 1000 0 0 ff 00 00 1 1
672 82 450 600 100 200 1000 1000 1000 1000 0 0 00 00 ff 1 1
676 82 450 600 100 200 1000 1000 1000 1000 37 37 c8 d2 c8 1 1
694 82 450 600 100 200 1000 1000 1000 1000 0 0 00 00 ff 1 1
702 82 450 600 100 200 1000 1000 1000 1000 127 127 00 00 ff 1 1
734 82 450 600 100 200 1000 1000 1000 1000 0 0 ff 00 00 1 1
738 82 450 600 100 200 1000 1000 1000 1000 37 37 c8 d2 c8 1 1
758 82 450 600 100 200 1000 1000 1000 1000 0 0 ff 00 00 1 1
766 82 450 600 100 200 1000 1000 1000 1000 127 127 ff 00 00 1 1
685 88 450 600 100 200 1000 1000 1000 1000 37 37 00 00 ff 1 1
747 88 450 600 100 200 1000 1000 1000 1000 37 37 ff 00 00 1 1
698 90 450 600 100 200 1000 1000 1000 1000 37 37 c8 d2 c8 1 1
762 90 450 600 100 200 1000 1000 1000 1000 37 37 c8 d2 c8 1 1
685 92 450 600 100 200 1000 1000 1000 1000 127 127 c8 d2 c8 1 1
689 92 450 600 100 200 1000 1000 1000 1000 127 127 c8 d2 c8 1 1
747 92 450 600 100 200 1000 1000 1000 1000 127 127 c8 d2 c8 1 1
753 92 450 600 100 200 1000 1000 1000 1000 127 127 c8 d2 c8 1 1
560 100 450 600 100 200 1000 1000 1000 1000 0 0 ff 00 00 1 1
672 100 450 600 100 200 1000 1000 1000 1000 0 0 c8 d2 c8 1 1
680 100 450 600 100 200 1000 1000 1000 1000 127 127 00 00 ff 1 1
694 100 450 600 100 200 1000 1000 1000 1000 0 0 c8 d2 c8 1 1
698 100 450 600 100 200 1000 1000 1000 1000 37 37 00 00 ff 1 1
734 100 450 600 100 200 1000 1000 1000 1000 0 0 c8 d2 c8 1 1
742 100 450 600 100 200 1000 1000 1000 1000 127 127 ff 00 00 1 1
758 100 450 600 100 200 1000 1000 1000 1000 0 0 c8 d2 c8 1 1
762 100 450 600 100 200 1000 1000 1000 1000 37 37 ff 00 00 1 1
144 200 450 600 100 200 1000 1000 1000 1000 0 0 ff ff ff 1 1
660 200 450 600 100 200 1000 1000 1000 1000 0 0 00 00 00 1 1
350 230 450 600 100 200 350 230 1000 1000 0 0 ff 00 ff 1 1
560 240 450 600 240 200 560 240 1000 1000 0 0 ff 00 ff 1 1
400 275 450 600 100 200 1000 1000 1000 1000 0 0 ff ff ff 1 1
720 300 450 600 100 200 1000 1000 1000 1000 0 0 c8 d2 c8 1 1
790 300 450 600 100 200 1000 1000 1000 1000 0 0 00 00 00 1 1
450 320 450 600 100 200 1000 1000 450 320 0 0 ff ff 00 1 1
520 370 450 520 100 200 1000 1000 520 370 0 0 ff ff 00 1 1
400 430 450 600 100 200 1000 1000 1000 1000 0 0 00 00 00 1 1
440 430 450 600 100 200 1000 1000 1000 1000 0 0 00 00 ff 1 1
240 450 450 600 100 200 1000 1000 1000 1000 0 0 00 00 ff 1 1

// ==== list.f ====
logic/arena_pkg.sv
logic/raster_timing.sv
logic/pitch_painter.sv
logic/segment_digit.sv
logic/score_board.sv
logic/pixel_composer.sv
logic/arena_display.sv
tests/arena_display_assertions.sv
tests/arena_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the arena display testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module arena_display_tb -f list.f -o arena_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/arena_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
